/* design/cam_cfg.svh */
/*
 * Camera constants: fixed-point format, rotation step and move scales
 */
`ifndef CAM_CFG_SVH
`define CAM_CFG_SVH

// signed Q16.16 throughout
`define CAM_FRAC_BITS 16
`define CAM_ONE       32'h0001_0000

// rotation step of about 10 degrees
// cos = 64540 / 65536, sin = 11380 / 65536
`define CAM_COS       32'h0000_FC1C
`define CAM_SIN       32'h0000_2C74

// eye step per move, picked by keys 7, 8, 9 and 0
`define CAM_SCALE_1   32'h0001_0000
`define CAM_SCALE_2   32'h0002_0000
`define CAM_SCALE_4   32'h0004_0000
`define CAM_SCALE_8   32'h0008_0000

`endif

/* design/input_pkg.sv */
/*
 * Key event packet and decoded camera command types
 */
package input_pkg;

	// per key: bit 0 make pulse, bit 1 break pulse
	typedef struct packed {
		logic [1:0] d;
		logic [1:0] a;
		logic [1:0] e;
		logic [1:0] q;
		logic [1:0] w;
		logic [1:0] s;
		logic [1:0] l;
		logic [1:0] j;
		logic [1:0] o;
		logic [1:0] u;
		logic [1:0] i;
		logic [1:0] k;
		logic [1:0] n7;
		logic [1:0] n8;
		logic [1:0] n9;
		logic [1:0] n0;
	} keys_t;

	typedef enum logic [1:0] {CMD_NONE, CMD_MOVE, CMD_ROTATE, CMD_SCALE} cam_kind_t;

	// rotation axis, or U/V/W selection for a move
	typedef enum logic [1:0] {AXIS_X, AXIS_Y, AXIS_Z} axis_t;

	typedef struct packed {
		cam_kind_t  kind;
		axis_t      axis;
		logic       neg;
		logic [1:0] scale_sel;
		logic       released;   // break of any movement key
	} cam_cmd_t;

endpackage

/* design/geom_pkg.sv */
/*
 * Fixed-point scalar, vector and basis types, and the Q16.16 multiply
 */
`include "cam_cfg.svh"

package geom_pkg;

	typedef logic signed [31:0] fix_t;

	typedef struct packed {
		fix_t x;
		fix_t y;
		fix_t z;
	} vector_t;

	// index 0 is U, 1 is V, 2 is W
	typedef vector_t [2:0] basis_t;

	// full 64-bit product, arithmetic shift, wraps to one word
	function automatic fix_t fix_mul(fix_t a, fix_t b);
		logic signed [63:0] p;
		p = a * b;
		return fix_t'(p >>> `CAM_FRAC_BITS);
	endfunction

endpackage

/* design/key_decoder.sv */
/*
 * key_decoder: registers key pulses and encodes one camera command
 */
`timescale 1ns/1ps

module key_decoder (
	input  logic                clk,
	input  logic                rst,
	input  input_pkg::keys_t    keys,
	output input_pkg::cam_cmd_t cmd
);

	input_pkg::keys_t keys_q;
	logic [15:0] make;

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			keys_q <= '0;
		else
			keys_q <= keys;
	end

	assign make = {keys_q.d[0], keys_q.a[0], keys_q.e[0], keys_q.q[0],
		keys_q.w[0], keys_q.s[0], keys_q.l[0], keys_q.j[0],
		keys_q.o[0], keys_q.u[0], keys_q.i[0], keys_q.k[0],
		keys_q.n7[0], keys_q.n8[0], keys_q.n9[0], keys_q.n0[0]};

	// exactly one make bit gives a command, anything else is none
	always_comb begin
		cmd = '0;
		cmd.kind = input_pkg::CMD_NONE;
		cmd.axis = input_pkg::AXIS_X;
		cmd.released = |{keys_q.d[1], keys_q.a[1], keys_q.e[1], keys_q.q[1],
			keys_q.w[1], keys_q.s[1]};
		case (make)
			16'h8000: begin cmd.kind = input_pkg::CMD_MOVE;   cmd.axis = input_pkg::AXIS_X; end
			16'h4000: begin cmd.kind = input_pkg::CMD_MOVE;   cmd.axis = input_pkg::AXIS_X; cmd.neg = 1'b1; end
			16'h2000: begin cmd.kind = input_pkg::CMD_MOVE;   cmd.axis = input_pkg::AXIS_Y; end
			16'h1000: begin cmd.kind = input_pkg::CMD_MOVE;   cmd.axis = input_pkg::AXIS_Y; cmd.neg = 1'b1; end
			16'h0800: begin cmd.kind = input_pkg::CMD_MOVE;   cmd.axis = input_pkg::AXIS_Z; end
			16'h0400: begin cmd.kind = input_pkg::CMD_MOVE;   cmd.axis = input_pkg::AXIS_Z; cmd.neg = 1'b1; end
			// l/j about Y, o/u about X, i/k about Z
			16'h0200: begin cmd.kind = input_pkg::CMD_ROTATE; cmd.axis = input_pkg::AXIS_Y; end
			16'h0100: begin cmd.kind = input_pkg::CMD_ROTATE; cmd.axis = input_pkg::AXIS_Y; cmd.neg = 1'b1; end
			16'h0080: begin cmd.kind = input_pkg::CMD_ROTATE; cmd.axis = input_pkg::AXIS_X; end
			16'h0040: begin cmd.kind = input_pkg::CMD_ROTATE; cmd.axis = input_pkg::AXIS_X; cmd.neg = 1'b1; end
			16'h0020: begin cmd.kind = input_pkg::CMD_ROTATE; cmd.axis = input_pkg::AXIS_Z; end
			16'h0010: begin cmd.kind = input_pkg::CMD_ROTATE; cmd.axis = input_pkg::AXIS_Z; cmd.neg = 1'b1; end
			16'h0008: begin cmd.kind = input_pkg::CMD_SCALE;  cmd.scale_sel = 2'd0; end
			16'h0004: begin cmd.kind = input_pkg::CMD_SCALE;  cmd.scale_sel = 2'd1; end
			16'h0002: begin cmd.kind = input_pkg::CMD_SCALE;  cmd.scale_sel = 2'd2; end
			16'h0001: begin cmd.kind = input_pkg::CMD_SCALE;  cmd.scale_sel = 2'd3; end
			default: ;
		endcase
	end

endmodule

/* design/camera_fsm.sv */
/*
 * camera_fsm: idle/rotating/rendering control, step pulses and move scale
 */
`timescale 1ns/1ps
`include "cam_cfg.svh"

module camera_fsm (
	input  logic                clk,
	input  logic                rst,
	input  input_pkg::cam_cmd_t cmd,
	input  logic                rendering_done,
	output logic                render_frame,
	output logic                rot_step,
	output input_pkg::axis_t    rot_axis,
	output logic                rot_neg,
	output logic                move_step,
	output input_pkg::axis_t    move_sel,
	output logic                move_neg,
	output geom_pkg::fix_t      move_scale
);

	typedef enum logic [1:0] {IDLE, ROTATING, RENDERING} state_t;

	state_t state, state_n;
	input_pkg::axis_t sel_q;
	logic neg_q;
	logic is_move, is_rotate, is_scale;
	geom_pkg::fix_t scale_n;

	assign is_move = (cmd.kind == input_pkg::CMD_MOVE);
	assign is_rotate = (cmd.kind == input_pkg::CMD_ROTATE);
	assign is_scale = (cmd.kind == input_pkg::CMD_SCALE);

	always_comb begin
		state_n = state;
		render_frame = 1'b0;
		move_step = 1'b0;
		case (state)
			IDLE: begin
				if (is_rotate) begin
					render_frame = 1'b1;
					state_n = ROTATING;
				end else if (is_move) begin
					move_step = 1'b1;
					render_frame = 1'b1;
					state_n = RENDERING;
				end
			end
			ROTATING: state_n = IDLE;
			RENDERING: begin
				// key still held, step again on each finished frame
				if (cmd.released)
					state_n = IDLE;
				else if (rendering_done) begin
					move_step = 1'b1;
					render_frame = 1'b1;
				end
			end
			default: state_n = IDLE;
		endcase
	end

	assign rot_step = (state == ROTATING);

	// first step of a session comes straight from the command
	assign move_sel = (state == IDLE) ? cmd.axis : sel_q;
	assign move_neg = (state == IDLE) ? cmd.neg : neg_q;

	always_comb begin
		case (cmd.scale_sel)
			2'd0: scale_n = `CAM_SCALE_1;
			2'd1: scale_n = `CAM_SCALE_2;
			2'd2: scale_n = `CAM_SCALE_4;
			default: scale_n = `CAM_SCALE_8;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= IDLE;
			sel_q <= input_pkg::AXIS_X;
			neg_q <= 1'b0;
			rot_axis <= input_pkg::AXIS_X;
			rot_neg <= 1'b0;
			move_scale <= `CAM_SCALE_1;
		end else begin
			state <= state_n;
			if (state == IDLE) begin
				if (is_move) begin
					sel_q <= cmd.axis;
					neg_q <= cmd.neg;
				end
				if (is_rotate) begin
					rot_axis <= cmd.axis;
					rot_neg <= cmd.neg;
				end
				if (is_scale)
					move_scale <= scale_n;
			end
		end
	end

endmodule

/* design/basis_rotator.sv */
/*
 * One basis vector register, rotated about a world axis on each step
 */
`timescale 1ns/1ps
`include "cam_cfg.svh"

module basis_rotator (
	input  logic                clk,
	input  logic                rst,
	input  geom_pkg::vector_t   init,
	input  logic                step,
	input  input_pkg::axis_t    axis,
	input  logic                neg,
	output geom_pkg::vector_t   vec
);

	localparam geom_pkg::fix_t COS_STEP = `CAM_COS;

	geom_pkg::fix_t s, ns;
	geom_pkg::fix_t a, b, a_n, b_n;
	geom_pkg::vector_t vec_n;

	assign s = neg ? -geom_pkg::fix_t'(`CAM_SIN) : geom_pkg::fix_t'(`CAM_SIN);
	assign ns = -s;

	// pick the two components in the plane of rotation
	// (x, z) for Y, (y, x) for Z, (z, y) for X
	always_comb begin
		case (axis)
			input_pkg::AXIS_X: begin
				a = vec.z;
				b = vec.y;
			end
			input_pkg::AXIS_Z: begin
				a = vec.y;
				b = vec.x;
			end
			default: begin
				a = vec.x;
				b = vec.z;
			end
		endcase
	end

	// a' = c*a + s*b, b' = -s*a + c*b
	assign a_n = geom_pkg::fix_mul(COS_STEP, a) + geom_pkg::fix_mul(s, b);
	assign b_n = geom_pkg::fix_mul(ns, a) + geom_pkg::fix_mul(COS_STEP, b);

	always_comb begin
		vec_n = vec;
		case (axis)
			input_pkg::AXIS_X: begin
				vec_n.z = a_n;
				vec_n.y = b_n;
			end
			input_pkg::AXIS_Z: begin
				vec_n.y = a_n;
				vec_n.x = b_n;
			end
			default: begin
				vec_n.x = a_n;
				vec_n.z = b_n;
			end
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			vec <= init;
		else if (step)
			vec <= vec_n;
	end

endmodule

/* design/eye_integrator.sv */
/*
 * eye_integrator: eye position, stepped along U, V or W times the scale
 */
`timescale 1ns/1ps

module eye_integrator (
	input  logic              clk,
	input  logic              rst,
	input  logic              step,
	input  input_pkg::axis_t  sel,
	input  logic              neg,
	input  geom_pkg::fix_t    scale,
	input  geom_pkg::vector_t U,
	input  geom_pkg::vector_t V,
	input  geom_pkg::vector_t W,
	output geom_pkg::vector_t E
);

	geom_pkg::vector_t dir;
	geom_pkg::vector_t delta;

	// X selects U, Y selects V, Z selects W
	always_comb begin
		case (sel)
			input_pkg::AXIS_Y: dir = V;
			input_pkg::AXIS_Z: dir = W;
			default: dir = U;
		endcase
	end

	assign delta.x = geom_pkg::fix_mul(dir.x, scale);
	assign delta.y = geom_pkg::fix_mul(dir.y, scale);
	assign delta.z = geom_pkg::fix_mul(dir.z, scale);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			E <= '0;
		end else if (step) begin
			if (neg) begin
				E.x <= E.x - delta.x;
				E.y <= E.y - delta.y;
				E.z <= E.z - delta.z;
			end else begin
				E.x <= E.x + delta.x;
				E.y <= E.y + delta.y;
				E.z <= E.z + delta.z;
			end
		end
	end

endmodule

/* design/camera_top.sv */
/*
 * camera_top: key decoder, control FSM, three basis rotators, eye integrator
 */
`timescale 1ns/1ps
`include "cam_cfg.svh"

module camera_top (
	input  logic              clk,
	input  logic              rst,
	input  input_pkg::keys_t  keys,
	input  logic              rendering_done,
	output logic              render_frame,
	output geom_pkg::vector_t E,
	output geom_pkg::vector_t U,
	output geom_pkg::vector_t V,
	output geom_pkg::vector_t W
);

	// reset basis: unit X, Y, Z for U, V, W
	localparam geom_pkg::basis_t BASIS_INIT = {
		{32'h0, 32'h0, `CAM_ONE},
		{32'h0, `CAM_ONE, 32'h0},
		{`CAM_ONE, 32'h0, 32'h0}
	};

	input_pkg::cam_cmd_t cmd;
	logic rot_step, rot_neg;
	logic move_step, move_neg;
	input_pkg::axis_t rot_axis, move_sel;
	geom_pkg::fix_t move_scale;
	geom_pkg::basis_t basis;

	key_decoder u_key_decoder (
		.clk(clk),
		.rst(rst),
		.keys(keys),
		.cmd(cmd)
	);

	camera_fsm u_camera_fsm (
		.clk(clk),
		.rst(rst),
		.cmd(cmd),
		.rendering_done(rendering_done),
		.render_frame(render_frame),
		.rot_step(rot_step),
		.rot_axis(rot_axis),
		.rot_neg(rot_neg),
		.move_step(move_step),
		.move_sel(move_sel),
		.move_neg(move_neg),
		.move_scale(move_scale)
	);

	for (genvar g = 0; g < 3; g++) begin : g_basis
		basis_rotator u_basis_rotator (
			.clk(clk),
			.rst(rst),
			.init(BASIS_INIT[g]),
			.step(rot_step),
			.axis(rot_axis),
			.neg(rot_neg),
			.vec(basis[g])
		);
	end

	assign U = basis[0];
	assign V = basis[1];
	assign W = basis[2];

	eye_integrator u_eye_integrator (
		.clk(clk),
		.rst(rst),
		.step(move_step),
		.sel(move_sel),
		.neg(move_neg),
		.scale(move_scale),
		.U(basis[0]),
		.V(basis[1]),
		.W(basis[2]),
		.E(E)
	);

endmodule

/* tb/tb_camera_top.sv */
/*
 * Testbench for camera_top: clock and reset, stimulus read from a data file,
 * compare tasks for the eye and basis vectors and for render_frame
 */
`timescale 1ns/1ps

module tb_camera_top;

	localparam string DATA_FILE = "tb/camera_testdata.txt";
	localparam int WAIT_LIMIT = 20;

	logic clk;
	logic rst;
	input_pkg::keys_t keys;
	logic rendering_done;
	logic render_frame;
	geom_pkg::vector_t E;
	geom_pkg::vector_t U;
	geom_pkg::vector_t V;
	geom_pkg::vector_t W;

	camera_top u_camera_top (
		.clk(clk),
		.rst(rst),
		.keys(keys),
		.rendering_done(rendering_done),
		.render_frame(render_frame),
		.E(E),
		.U(U),
		.V(V),
		.W(W)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("STATUS: FAIL");
		$fatal(1, "run aborted");
	endtask

	task automatic check_vec(input string what, input geom_pkg::vector_t exp_v,
		input geom_pkg::vector_t got_v);
		if (got_v !== exp_v)
			abort_run($sformatf("mismatch at %0t: %s expected (%h %h %h) got (%h %h %h)",
				$time, what, exp_v.x, exp_v.y, exp_v.z, got_v.x, got_v.y, got_v.z));
	endtask

	task automatic check_pulse(input string what, input int exp_cycles, input int got_cycles);
		if (got_cycles != exp_cycles)
			abort_run($sformatf("mismatch at %0t: %s render_frame high %0d cycles, expected %0d",
				$time, what, got_cycles, exp_cycles));
	endtask

	// bit 0 make, bit 1 break
	task automatic drive_key(input string name, input logic [1:0] code);
		if (name == "d") keys.d = code;
		else if (name == "a") keys.a = code;
		else if (name == "e") keys.e = code;
		else if (name == "q") keys.q = code;
		else if (name == "w") keys.w = code;
		else if (name == "s") keys.s = code;
		else if (name == "l") keys.l = code;
		else if (name == "j") keys.j = code;
		else if (name == "o") keys.o = code;
		else if (name == "u") keys.u = code;
		else if (name == "i") keys.i = code;
		else if (name == "k") keys.k = code;
		else if (name == "n7") keys.n7 = code;
		else if (name == "n8") keys.n8 = code;
		else if (name == "n9") keys.n9 = code;
		else if (name == "n0") keys.n0 = code;
		else abort_run($sformatf("unknown key name '%s' in the data file", name));
	endtask

	// called 1 ns after a rising edge, returns 1 ns after a rising edge
	task automatic run_step(input int line_no, input string op, input string key1,
		input string key2, input int exp_pulse, input geom_pkg::vector_t exp_e,
		input geom_pkg::vector_t exp_u, input geom_pkg::vector_t exp_v,
		input geom_pkg::vector_t exp_w);
		int idx;
		int high_cycles;
		bit settled;
		string tag;
		idx = 0;
		high_cycles = 0;
		settled = 1'b0;
		tag = $sformatf("line %0d %s", line_no, op);
		if (op == "make")
			drive_key(key1, 2'b01);
		else if (op == "break")
			drive_key(key1, 2'b10);
		else if (op == "both") begin
			drive_key(key1, 2'b01);
			drive_key(key2, 2'b01);
		end else if (op == "done")
			rendering_done = 1'b1;
		else if (op != "idle")
			abort_run($sformatf("unknown action '%s' on data file line %0d", op, line_no));
		// at least 3 edges, longer only while an expected pulse is missing
		while (!settled) begin
			@(negedge clk);
			if (render_frame)
				high_cycles++;
			if (idx >= 3 && (exp_pulse == 0 || high_cycles > 0)) begin
				settled = 1'b1;
			end else if (idx == WAIT_LIMIT - 1) begin
				abort_run($sformatf("timeout: no render_frame within %0d cycles for %s",
					WAIT_LIMIT, tag));
			end else begin
				@(posedge clk);
				#1;
				keys = '0;
				rendering_done = 1'b0;
				idx++;
			end
		end
		check_pulse(tag, exp_pulse, high_cycles);
		check_vec({tag, " E"}, exp_e, E);
		check_vec({tag, " U"}, exp_u, U);
		check_vec({tag, " V"}, exp_v, V);
		check_vec({tag, " W"}, exp_w, W);
		@(posedge clk);
		#1;
	endtask

	initial begin
		int fd;
		int line_no;
		int steps;
		int fields;
		int exp_pulse;
		string line;
		string op;
		string key1;
		string key2;
		geom_pkg::fix_t word [0:11];
		rst = 1'b1;
		keys = '0;
		rendering_done = 1'b0;
		line_no = 0;
		steps = 0;
		fd = $fopen(DATA_FILE, "r");
		if (fd == 0)
			abort_run({"could not open the data file ", DATA_FILE});
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;
		while ($fgets(line, fd) != 0) begin
			line_no++;
			if (line.len() < 2 || line.getc(0) == "#")
				continue;
			fields = $sscanf(line, "%s %s %s %d %h %h %h %h %h %h %h %h %h %h %h %h",
				op, key1, key2, exp_pulse, word[0], word[1], word[2], word[3],
				word[4], word[5], word[6], word[7], word[8], word[9], word[10], word[11]);
			if (fields != 16)
				abort_run($sformatf("data file line %0d is malformed, %0d fields read",
					line_no, fields));
			run_step(line_no, op, key1, key2, exp_pulse,
				{word[0], word[1], word[2]}, {word[3], word[4], word[5]},
				{word[6], word[7], word[8]}, {word[9], word[10], word[11]});
			steps++;
		end
		$fclose(fd);
		if (steps == 0) begin
			abort_run("the data file held no test steps");
		end else begin
			$display("STATUS: PASS");
			$finish;
		end
	end

endmodule

/* tb/camera_testdata.txt */
# action key1 key2 render_frame_cycles  E.x E.y E.z  U.x U.y U.z  V.x V.y V.z  W.x W.y W.z
# actions: make, break, both (two makes at once), done (rendering_done), idle
# vector words are Q16.16 in hex, negatives as 32-bit two's complement
idle - - 0 0 0 0 10000 0 0 0 10000 0 0 0 10000
make l - 1 0 0 0 fc1c 0 ffffd38c 0 10000 0 2c74 0 fc1c
make l - 1 0 0 0 f08e 0 ffffa870 0 10000 0 578e 0 f08e
make w - 1 578e 0 f08e f08e 0 ffffa870 0 10000 0 578e 0 f08e
done - - 1 af1c 0 1e11c f08e 0 ffffa870 0 10000 0 578e 0 f08e
make l - 0 af1c 0 1e11c f08e 0 ffffa870 0 10000 0 578e 0 f08e
make n0 - 0 af1c 0 1e11c f08e 0 ffffa870 0 10000 0 578e 0 f08e
done - - 1 106aa 0 2d1aa f08e 0 ffffa870 0 10000 0 578e 0 f08e
break w - 0 106aa 0 2d1aa f08e 0 ffffa870 0 10000 0 578e 0 f08e
done - - 0 106aa 0 2d1aa f08e 0 ffffa870 0 10000 0 578e 0 f08e
make n9 - 0 106aa 0 2d1aa f08e 0 ffffa870 0 10000 0 578e 0 f08e
make s - 1 ffffa872 0 ffff0f72 f08e 0 ffffa870 0 10000 0 578e 0 f08e
done - - 1 fffe4a3a 0 fffb4d3a f08e 0 ffffa870 0 10000 0 578e 0 f08e
break s - 0 fffe4a3a 0 fffb4d3a f08e 0 ffffa870 0 10000 0 578e 0 f08e
both l d 0 fffe4a3a 0 fffb4d3a f08e 0 ffffa870 0 10000 0 578e 0 f08e
make d - 1 20c72 0 fff9eefa f08e 0 ffffa870 0 10000 0 578e 0 f08e
break d - 0 20c72 0 fff9eefa f08e 0 ffffa870 0 10000 0 578e 0 f08e
make j - 1 20c72 0 fff9eefa fc1a 0 ffffd389 0 10000 0 2c73 0 fc1a
done - - 0 20c72 0 fff9eefa fc1a 0 ffffd389 0 10000 0 2c73 0 fc1a

/* compile.f */
+incdir+design
design/input_pkg.sv
design/geom_pkg.sv
design/key_decoder.sv
design/camera_fsm.sv
design/basis_rotator.sv
design/eye_integrator.sv
design/camera_top.sv
tb/tb_camera_top.sv

/* Makefile */
# Verilator flow for the camera control block
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := tb_camera_top
FILELIST  := compile.f
OBJDIR    := obj_dir
LOG       := sim.log

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

# the run passes only if the log holds the pass line
sim: build
	./$(OBJDIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
